// ==== build.f ====
+incdir+design
design/wb_bus_pkg.sv
design/soc_map_pkg.sv
design/wb_host_port.sv
design/soc_address_decoder.sv
design/sram_bank_pair.sv
design/id_register_block.sv
design/experiar_soc.sv
test/experiar_soc_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vexperiar_soc_tb

.PHONY: all run clean

all: $(SIM)

$(SIM): build.f $(wildcard design/*.sv design/*.svh test/*.sv)
	verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
		--top-module experiar_soc_tb -f build.f

# Pass only when the simulation prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// ==== test/experiar_soc_tb.sv ====
`include "soc_consts.svh"

module experiar_soc_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import soc_map_pkg::*;

	localparam int TIMEOUT_CYCLES = 40;
	localparam int MEM_WORDS = 12;

	logic wb_clk;
	logic arst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`WB_SEL_W-1:0] wb_sel;
	logic [`WB_DATA_W-1:0] wb_wdata;
	logic [`WB_ADDR_W-1:0] wb_adr;
	logic wb_ack;
	logic wb_stall;
	logic wb_error;
	logic [`WB_DATA_W-1:0] wb_rdata;
	logic [10:0] manufacturer_id;
	logic [15:0] part_id;
	logic [3:0] version_id;
	logic [7:0] core0_index;
	logic [7:0] core1_index;
	soc_probe_t probe;

	int data_errors;
	int protocol_errors;
	int timeout_errors;
	logic accept_now;
	logic [`SLAVE_SEL_W-1:0] last_slave;
	// Model of both banks, indexed by bank bit and word index
	logic [31:0] mem_model [1024];
	logic [9:0] keys [$];

	experiar_soc dut_i (
		.wb_clk_i(wb_clk),
		.arst_n_i(arst_n),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.wb_we_i(wb_we),
		.wb_sel_i(wb_sel),
		.wb_data_i(wb_wdata),
		.wb_adr_i(wb_adr),
		.wb_ack_o(wb_ack),
		.wb_stall_o(wb_stall),
		.wb_error_o(wb_error),
		.wb_data_o(wb_rdata),
		.manufacturer_id_i(manufacturer_id),
		.part_id_i(part_id),
		.version_id_i(version_id),
		.core0_index_i(core0_index),
		.core1_index_i(core1_index),
		.probe_o(probe)
	);

	always #50 wb_clk = ~wb_clk;

	assign accept_now = wb_cyc && wb_stb && !wb_stall;

	always @(posedge wb_clk) begin
		if (accept_now)
			last_slave <= wb_adr[27:24];
	end

	task automatic note_protocol_error(input string what);
		protocol_errors++;
		$display("protocol error: %s", what);
	endtask

	assert property (@(posedge wb_clk) disable iff (!arst_n) !(wb_ack && wb_error))
		else note_protocol_error("ack and error high together");
	assert property (@(posedge wb_clk) disable iff (!arst_n) wb_ack |=> !wb_ack)
		else note_protocol_error("ack held longer than one cycle");
	assert property (@(posedge wb_clk) disable iff (!arst_n) wb_error |=> !wb_error)
		else note_protocol_error("error held longer than one cycle");
	assert property (@(posedge wb_clk) disable iff (!arst_n) accept_now |=> wb_stall)
		else note_protocol_error("stall low right after an accepted request");
	assert property (@(posedge wb_clk) disable iff (!arst_n) (wb_ack || wb_error) |-> wb_stall)
		else note_protocol_error("stall dropped before the response cycle");
	// Ack registered at edge 4 and error at edge 3, each sampled one edge later
	assert property (@(posedge wb_clk) disable iff (!arst_n)
		wb_ack |-> $past(accept_now, 5) && $past(wb_adr[27:24], 5) <= 4'd1)
		else note_protocol_error("ack not four edges after a mapped request");
	assert property (@(posedge wb_clk) disable iff (!arst_n)
		wb_error |-> $past(accept_now, 4) && $past(wb_adr[27:24], 4) > 4'd1)
		else note_protocol_error("error not three edges after an unmapped request");
	// Probe tracks the request in flight
	assert property (@(posedge wb_clk) disable iff (!arst_n) $past(accept_now, 2) |-> probe.active)
		else note_protocol_error("probe inactive while a request is outstanding");
	assert property (@(posedge wb_clk) disable iff (!arst_n) probe.active |-> probe.slave == last_slave)
		else note_protocol_error("probe slave field differs from the request address");

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else begin
			data_errors++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Byte lanes with sel set take the new word
	function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] sel);
		logic [31:0] merged;
		merged = old_word;
		for (int l = 0; l < 4; l++) begin
			if (sel[l])
				merged[8*l +: 8] = new_word[8*l +: 8];
		end
		return merged;
	endfunction

	// Unused offset bits are randomized, the slave ignores them
	function automatic logic [27:0] mem_address(input logic [9:0] key);
		return {4'(`SLAVE_MEMORY), 12'($urandom), key, 2'b00};
	endfunction

	function automatic logic [27:0] id_address(input logic [1:0] index);
		return {4'(`SLAVE_ID), 20'($urandom), index, 2'b00};
	endfunction

	task automatic wait_accept(output bit accepted);
		int waited;
		waited = 0;
		accepted = 1'b0;
		while (!accepted && waited < TIMEOUT_CYCLES) begin
			@(posedge wb_clk);
			waited++;
			accepted = !wb_stall;
		end
		if (!accepted) begin
			timeout_errors++;
			$display("timeout: stall never dropped for the request at %h", wb_adr);
		end
	endtask

	task automatic wait_response(output logic [31:0] rdata, output logic err);
		int waited;
		bit seen;
		waited = 0;
		seen = 1'b0;
		rdata = '0;
		err = 1'b0;
		while (!seen && waited < TIMEOUT_CYCLES) begin
			@(posedge wb_clk);
			waited++;
			seen = wb_ack || wb_error;
		end
		if (seen) begin
			rdata = wb_rdata;
			err = wb_error;
		end else begin
			timeout_errors++;
			$display("timeout: no ack or error for the request at %h", wb_adr);
		end
	endtask

	task automatic bus_access(input logic we, input logic [3:0] sel, input logic [31:0] data,
		input logic [27:0] adr, output logic [31:0] rdata, output logic err);
		bit accepted;
		@(posedge wb_clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_sel <= sel;
		wb_wdata <= data;
		wb_adr <= adr;
		wait_accept(accepted);
		wb_stb <= 1'b0;
		rdata = '0;
		err = 1'b0;
		if (accepted)
			wait_response(rdata, err);
		wb_cyc <= 1'b0;
	endtask

	// Write held on stb, then a read of the same word queued behind it
	task automatic back_to_back(input logic [9:0] key, input logic [31:0] data);
		bit accepted;
		bit second_taken;
		int responses;
		int waited;
		logic [31:0] rdata;
		@(posedge wb_clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b1;
		wb_sel <= 4'hf;
		wb_wdata <= data;
		wb_adr <= mem_address(key);
		wait_accept(accepted);
		wb_we <= 1'b0;
		wb_adr <= mem_address(key);
		second_taken = 1'b0;
		responses = 0;
		waited = 0;
		rdata = '0;
		while (accepted && responses < 2 && waited < TIMEOUT_CYCLES) begin
			@(posedge wb_clk);
			waited++;
			if (wb_ack || wb_error) begin
				responses++;
				rdata = wb_rdata;
			end
			if (!second_taken && !wb_stall) begin
				second_taken = 1'b1;
				wb_stb <= 1'b0;
				check_value("responses before second accept", 32'd1, 32'(responses));
			end
		end
		wb_stb <= 1'b0;
		wb_cyc <= 1'b0;
		if (accepted && responses < 2) begin
			timeout_errors++;
			$display("timeout: back-to-back requests did not both complete");
		end
		mem_model[key] = data;
		check_value("back-to-back read", mem_model[key], rdata);
	endtask

	initial begin
		logic [31:0] rdata;
		logic err;
		logic [31:0] data;
		logic [3:0] sel;
		logic [9:0] key;
		logic [8:0] word;
		logic [31:0] scratch_model;
		void'($urandom(87));
		wb_clk = 1'b0;
		arst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_sel = '0;
		wb_wdata = '0;
		wb_adr = '0;
		manufacturer_id = 11'h5a3;
		part_id = 16'hc0de;
		version_id = 4'h2;
		core0_index = 8'h3c;
		core1_index = 8'hc5;
		data_errors = 0;
		protocol_errors = 0;
		timeout_errors = 0;
		word = '0;
		repeat (10) @(posedge wb_clk);
		arst_n <= 1'b1;
		@(posedge wb_clk);
		check_value("reset state", 32'd0, {28'd0, wb_ack, wb_error, wb_stall, probe.active});

		// Full words first, so partial writes have a known base
		for (int i = 0; i < MEM_WORDS; i++) begin
			// Same word index in both banks, so aliased banks show up
			if (!i[0])
				word = 9'($urandom);
			key = {i[0], word};
			data = $urandom;
			bus_access(1'b1, 4'hf, data, mem_address(key), rdata, err);
			check_value("memory write error flag", 32'd0, 32'(err));
			mem_model[key] = data;
			keys.push_back(key);
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			sel = 4'($urandom);
			data = $urandom;
			bus_access(1'b1, sel, data, mem_address(keys[i]), rdata, err);
			check_value("memory masked write error flag", 32'd0, 32'(err));
			mem_model[keys[i]] = merge_lanes(mem_model[keys[i]], data, sel);
		end
		foreach (keys[i]) begin
			bus_access(1'b0, 4'hf, 32'd0, mem_address(keys[i]), rdata, err);
			check_value("memory read error flag", 32'd0, 32'(err));
			check_value($sformatf("memory read %h", keys[i]), mem_model[keys[i]], rdata);
		end

		bus_access(1'b0, 4'hf, 32'd0, id_address(2'd0), rdata, err);
		check_value("idcode read", {version_id, part_id, manufacturer_id, 1'b1}, rdata);
		bus_access(1'b0, 4'hf, 32'd0, id_address(2'd1), rdata, err);
		check_value("core index read", {16'd0, core1_index, core0_index}, rdata);
		bus_access(1'b0, 4'hf, 32'd0, id_address(2'd3), rdata, err);
		check_value("reserved register read", 32'd0, rdata);
		bus_access(1'b1, 4'hf, $urandom, id_address(2'd0), rdata, err);
		bus_access(1'b0, 4'hf, 32'd0, id_address(2'd0), rdata, err);
		check_value("idcode after write", {version_id, part_id, manufacturer_id, 1'b1}, rdata);

		scratch_model = 32'd0;
		bus_access(1'b0, 4'hf, 32'd0, id_address(2'd2), rdata, err);
		check_value("scratch after reset", scratch_model, rdata);
		repeat (6) begin
			sel = 4'($urandom);
			data = $urandom;
			bus_access(1'b1, sel, data, id_address(2'd2), rdata, err);
			scratch_model = merge_lanes(scratch_model, data, sel);
			bus_access(1'b0, 4'hf, 32'd0, id_address(2'd2), rdata, err);
			check_value("scratch read", scratch_model, rdata);
		end

		for (int s = 2; s < 16; s++) begin
			bus_access(1'($urandom), 4'($urandom), $urandom, {4'(s), 24'($urandom)}, rdata, err);
			check_value("unmapped error flag", 32'd1, 32'(err));
			check_value("unmapped read data", 32'd0, rdata);
		end

		back_to_back({1'b1, 9'($urandom)}, $urandom);

		repeat (3) @(posedge wb_clk);
		$display("errors: %0d mismatch, %0d protocol, %0d timeout",
			data_errors, protocol_errors, timeout_errors);
		if (data_errors == 0 && protocol_errors == 0 && timeout_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== design/experiar_soc.sv ====
`include "soc_consts.svh"

module experiar_soc (
	input  logic wb_clk_i,
	input  logic arst_n_i,
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [`WB_SEL_W-1:0] wb_sel_i,
	input  logic [`WB_DATA_W-1:0] wb_data_i,
	input  logic [`WB_ADDR_W-1:0] wb_adr_i,
	output logic wb_ack_o,
	output logic wb_stall_o,
	output logic wb_error_o,
	output logic [`WB_DATA_W-1:0] wb_data_o,
	input  logic [10:0] manufacturer_id_i,
	input  logic [15:0] part_id_i,
	input  logic [3:0] version_id_i,
	input  logic [7:0] core0_index_i,
	input  logic [7:0] core1_index_i,
	output soc_map_pkg::soc_probe_t probe_o
);
	import wb_bus_pkg::*;
	import soc_map_pkg::*;

	// Host port to decoder
	wb_req_t host_req;
	logic host_req_valid;
	logic host_req_ready;
	wb_resp_t host_resp;
	logic host_resp_valid;

	// Decoder to slaves
	wb_req_t slave_req;
	local_offset_u slave_offset;
	logic mem_req_valid;
	logic id_req_valid;
	logic mem_resp_valid;
	logic id_resp_valid;
	logic [`WB_DATA_W-1:0] mem_rdata;
	logic [`WB_DATA_W-1:0] id_rdata;

	wb_host_port host_port (
		.wb_clk_i(wb_clk_i),
		.arst_n_i(arst_n_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_sel_i(wb_sel_i),
		.wb_data_i(wb_data_i),
		.wb_adr_i(wb_adr_i),
		.wb_ack_o(wb_ack_o),
		.wb_stall_o(wb_stall_o),
		.wb_error_o(wb_error_o),
		.wb_data_o(wb_data_o),
		.host_req_o(host_req),
		.host_req_valid_o(host_req_valid),
		.host_req_ready_i(host_req_ready),
		.host_resp_i(host_resp),
		.host_resp_valid_i(host_resp_valid)
	);

	soc_address_decoder address_decoder (
		.wb_clk_i(wb_clk_i),
		.arst_n_i(arst_n_i),
		.host_req_i(host_req),
		.host_req_valid_i(host_req_valid),
		.host_req_ready_o(host_req_ready),
		.host_resp_o(host_resp),
		.host_resp_valid_o(host_resp_valid),
		.slave_req_o(slave_req),
		.slave_offset_o(slave_offset),
		.mem_req_valid_o(mem_req_valid),
		.id_req_valid_o(id_req_valid),
		.mem_resp_valid_i(mem_resp_valid),
		.id_resp_valid_i(id_resp_valid),
		.mem_rdata_i(mem_rdata),
		.id_rdata_i(id_rdata),
		.probe_o(probe_o)
	);

	// Slave 0, local memory
	sram_bank_pair local_memory (
		.wb_clk_i(wb_clk_i),
		.arst_n_i(arst_n_i),
		.req_valid_i(mem_req_valid),
		.req_i(slave_req),
		.offset_i(slave_offset),
		.resp_valid_o(mem_resp_valid),
		.rdata_o(mem_rdata)
	);

	// Slave 1, identification words
	id_register_block id_block (
		.wb_clk_i(wb_clk_i),
		.arst_n_i(arst_n_i),
		.req_valid_i(id_req_valid),
		.req_i(slave_req),
		.offset_i(slave_offset),
		.manufacturer_id_i(manufacturer_id_i),
		.part_id_i(part_id_i),
		.version_id_i(version_id_i),
		.core0_index_i(core0_index_i),
		.core1_index_i(core1_index_i),
		.resp_valid_o(id_resp_valid),
		.rdata_o(id_rdata)
	);

endmodule

// ==== design/id_register_block.sv ====
`include "soc_consts.svh"

module id_register_block (
	input  logic wb_clk_i,
	input  logic arst_n_i,
	input  logic req_valid_i,
	input  wb_bus_pkg::wb_req_t req_i,
	input  soc_map_pkg::local_offset_u offset_i,
	input  logic [10:0] manufacturer_id_i,
	input  logic [15:0] part_id_i,
	input  logic [3:0] version_id_i,
	input  logic [7:0] core0_index_i,
	input  logic [7:0] core1_index_i,
	output logic resp_valid_o,
	output logic [`WB_DATA_W-1:0] rdata_o
);
	localparam logic [`ID_REG_W-1:0] REG_IDCODE = 0;
	localparam logic [`ID_REG_W-1:0] REG_CORES = 1;
	localparam logic [`ID_REG_W-1:0] REG_SCRATCH = 2;

	logic [`WB_DATA_W-1:0] scratch_q;
	logic [`WB_DATA_W-1:0] rdata_q;
	logic [`WB_DATA_W-1:0] rd_word;
	logic resp_valid_q;

	always_comb begin
		case (offset_i.regs.index)
			REG_IDCODE: rd_word = {version_id_i, part_id_i, manufacturer_id_i, 1'b1};
			REG_CORES: rd_word = {16'b0, core1_index_i, core0_index_i};
			REG_SCRATCH: rd_word = scratch_q;
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			scratch_q <= '0;
			resp_valid_q <= 1'b0;
		end else begin
			resp_valid_q <= req_valid_i;
			// Only scratch is writable, other writes just get an ack
			if (req_valid_i && req_i.we && offset_i.regs.index == REG_SCRATCH) begin
				for (int l = 0; l < `WB_SEL_W; l++) begin
					if (req_i.sel[l])
						scratch_q[8*l +: 8] <= req_i.data[8*l +: 8];
				end
			end
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (req_valid_i)
			rdata_q <= rd_word;
	end

	assign resp_valid_o = resp_valid_q;
	assign rdata_o = rdata_q;

endmodule

// ==== design/sram_bank_pair.sv ====
`include "soc_consts.svh"

module sram_bank_pair (
	input  logic wb_clk_i,
	input  logic arst_n_i,
	input  logic req_valid_i,
	input  wb_bus_pkg::wb_req_t req_i,
	input  soc_map_pkg::local_offset_u offset_i,
	output logic resp_valid_o,
	output logic [`WB_DATA_W-1:0] rdata_o
);
	localparam int unsigned WORDS = 2 ** `SRAM_ADDR_W;

	// Per bank chip select, active low like the macros
	logic [`SRAM_BANKS-1:0] csb;
	logic [`SRAM_BANKS-1:0][`WB_DATA_W-1:0] dout;
	logic bank_q;
	logic resp_valid_q;

	for (genvar b = 0; b < `SRAM_BANKS; b++) begin : g_bank
		logic [`WB_DATA_W-1:0] mem [WORDS];
		logic [`WB_DATA_W-1:0] dout_q;

		assign csb[b] = !(req_valid_i && (offset_i.mem.bank == 1'(b)));

		// Read returns the word held before this edge
		always_ff @(posedge wb_clk_i) begin
			if (!csb[b]) begin
				dout_q <= mem[offset_i.mem.word];
				if (req_i.we) begin
					for (int l = 0; l < `WB_SEL_W; l++) begin
						if (req_i.sel[l])
							mem[offset_i.mem.word][8*l +: 8] <= req_i.data[8*l +: 8];
					end
				end
			end
		end

		assign dout[b] = dout_q;
	end

	always_ff @(posedge wb_clk_i) begin
		if (req_valid_i)
			bank_q <= offset_i.mem.bank;
	end

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			resp_valid_q <= 1'b0;
		else
			resp_valid_q <= req_valid_i;
	end

	// Both banks side by side, the saved bank bit picks one
	assign rdata_o = dout[bank_q];
	assign resp_valid_o = resp_valid_q;

	// No new request while the last response is still on the port
	assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		resp_valid_q |-> !req_valid_i);

endmodule

// ==== design/soc_address_decoder.sv ====
`include "soc_consts.svh"

module soc_address_decoder (
	input  logic wb_clk_i,
	input  logic arst_n_i,
	input  wb_bus_pkg::wb_req_t host_req_i,
	input  logic host_req_valid_i,
	output logic host_req_ready_o,
	output wb_bus_pkg::wb_resp_t host_resp_o,
	output logic host_resp_valid_o,
	output wb_bus_pkg::wb_req_t slave_req_o,
	output soc_map_pkg::local_offset_u slave_offset_o,
	output logic mem_req_valid_o,
	output logic id_req_valid_o,
	input  logic mem_resp_valid_i,
	input  logic id_resp_valid_i,
	input  logic [`WB_DATA_W-1:0] mem_rdata_i,
	input  logic [`WB_DATA_W-1:0] id_rdata_i,
	output soc_map_pkg::soc_probe_t probe_o
);
	import wb_bus_pkg::*;
	import soc_map_pkg::*;

	wb_req_t req_q;
	logic busy_q;
	logic issue_q;
	logic mem_valid_q;
	logic id_valid_q;
	logic err_valid_q;
	logic take;
	logic resp_valid;
	slave_sel_e slave_field;

	assign host_req_ready_o = !busy_q;
	assign take = host_req_valid_i && !busy_q;

	// Top address bits pick the slave, the rest is the local offset
	assign slave_field = slave_sel_e'(req_q.adr[`WB_ADDR_W-1 -: `SLAVE_SEL_W]);
	assign slave_offset_o = local_offset_u'(req_q.adr[`LOCAL_OFFSET_W-1:0]);
	assign slave_req_o = req_q;

	always_ff @(posedge wb_clk_i) begin
		if (take)
			req_q <= host_req_i;
	end

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q <= 1'b0;
			issue_q <= 1'b0;
			mem_valid_q <= 1'b0;
			id_valid_q <= 1'b0;
			err_valid_q <= 1'b0;
		end else begin
			issue_q <= take;
			mem_valid_q <= issue_q && (slave_field == SLAVE_SEL_MEMORY);
			id_valid_q <= issue_q && (slave_field == SLAVE_SEL_ID);
			// Unmapped field, answered here without a slave
			err_valid_q <= issue_q && !(slave_field inside {SLAVE_SEL_MEMORY, SLAVE_SEL_ID});
			if (take)
				busy_q <= 1'b1;
			else if (resp_valid)
				busy_q <= 1'b0;
		end
	end

	assign mem_req_valid_o = mem_valid_q;
	assign id_req_valid_o = id_valid_q;

	// Slave responses pass straight through
	assign resp_valid = err_valid_q || mem_resp_valid_i || id_resp_valid_i;
	assign host_resp_valid_o = resp_valid;

	always_comb begin
		host_resp_o.error = err_valid_q;
		if (mem_resp_valid_i)
			host_resp_o.data = mem_rdata_i;
		else if (id_resp_valid_i)
			host_resp_o.data = id_rdata_i;
		else
			host_resp_o.data = '0;
	end

	assign probe_o.slave = slave_field;
	assign probe_o.active = busy_q;

	// One request in flight, so no two slave or response valids overlap
	assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		$onehot0({mem_valid_q, id_valid_q, mem_resp_valid_i, id_resp_valid_i, err_valid_q}));

endmodule

// ==== design/wb_host_port.sv ====
`include "soc_consts.svh"

module wb_host_port (
	input  logic wb_clk_i,
	input  logic arst_n_i,
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [`WB_SEL_W-1:0] wb_sel_i,
	input  logic [`WB_DATA_W-1:0] wb_data_i,
	input  logic [`WB_ADDR_W-1:0] wb_adr_i,
	output logic wb_ack_o,
	output logic wb_stall_o,
	output logic wb_error_o,
	output logic [`WB_DATA_W-1:0] wb_data_o,
	output wb_bus_pkg::wb_req_t host_req_o,
	output logic host_req_valid_o,
	input  logic host_req_ready_i,
	input  wb_bus_pkg::wb_resp_t host_resp_i,
	input  logic host_resp_valid_i
);
	import wb_bus_pkg::*;

	wb_req_t req_q;
	logic req_valid_q;
	logic busy_q;
	logic ack_q;
	logic error_q;
	logic [`WB_DATA_W-1:0] rdata_q;
	logic accept;

	// New cycle only while no request is in flight
	assign accept = wb_cyc_i && wb_stb_i && !busy_q;

	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			req_q.we <= wb_we_i;
			req_q.sel <= wb_sel_i;
			req_q.data <= wb_data_i;
			req_q.adr <= wb_adr_i;
		end
	end

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			req_valid_q <= 1'b0;
			busy_q <= 1'b0;
			ack_q <= 1'b0;
			error_q <= 1'b0;
		end else begin
			if (accept)
				req_valid_q <= 1'b1;
			else if (host_req_ready_i)
				req_valid_q <= 1'b0;
			// Held through the ack or error cycle
			if (accept)
				busy_q <= 1'b1;
			else if (ack_q || error_q)
				busy_q <= 1'b0;
			ack_q <= host_resp_valid_i && !host_resp_i.error;
			error_q <= host_resp_valid_i && host_resp_i.error;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (host_resp_valid_i)
			rdata_q <= host_resp_i.data;
	end

	assign host_req_o = req_q;
	assign host_req_valid_o = req_valid_q;
	assign wb_stall_o = busy_q;
	assign wb_ack_o = ack_q;
	assign wb_error_o = error_q;
	assign wb_data_o = rdata_q;

	// Decoder has drained the last request before the host starts another
	assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		accept |-> host_req_ready_i && !req_valid_q);

endmodule

// ==== design/soc_map_pkg.sv ====
`include "soc_consts.svh"

package soc_map_pkg;

	// Slave field of the host address, other codes are unmapped
	typedef enum logic [`SLAVE_SEL_W-1:0] {
		SLAVE_SEL_MEMORY = `SLAVE_SEL_W'(`SLAVE_MEMORY),
		SLAVE_SEL_ID = `SLAVE_SEL_W'(`SLAVE_ID)
	} slave_sel_e;

	// Memory view, bank bit above the word index
	typedef struct packed {
		logic [`LOCAL_OFFSET_W-`SRAM_ADDR_W-4:0] unused;
		logic bank;
		logic [`SRAM_ADDR_W-1:0] word;
		logic [1:0] lane;
	} mem_view_t;

	// Register view for the ID block
	typedef struct packed {
		logic [`LOCAL_OFFSET_W-`ID_REG_W-3:0] unused;
		logic [`ID_REG_W-1:0] index;
		logic [1:0] lane;
	} reg_view_t;

	typedef union packed {
		mem_view_t mem;
		reg_view_t regs;
	} local_offset_u;

	// Host side current slave probe
	typedef struct packed {
		slave_sel_e slave;
		logic active;
	} soc_probe_t;

endpackage

// ==== design/wb_bus_pkg.sv ====
`include "soc_consts.svh"

package wb_bus_pkg;

	// One host transaction as taken from the Wishbone port
	typedef struct packed {
		logic we;
		logic [`WB_SEL_W-1:0] sel;
		logic [`WB_DATA_W-1:0] data;
		logic [`WB_ADDR_W-1:0] adr;
	} wb_req_t;

	// Answer to one transaction
	// Error carries zero data
	typedef struct packed {
		logic error;
		logic [`WB_DATA_W-1:0] data;
	} wb_resp_t;

endpackage

// ==== design/soc_consts.svh ====
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Wishbone host port
`define WB_ADDR_W 28
`define WB_DATA_W 32
`define WB_SEL_W 4

// Address split, top field picks the slave
`define SLAVE_SEL_W 4
`define LOCAL_OFFSET_W 24

// Local memory geometry, one bank per SRAM macro
`define SRAM_ADDR_W 9
`define SRAM_BANKS 2

// ID block register index
`define ID_REG_W 2

// Slave numbers in the address map
`define SLAVE_MEMORY 0
`define SLAVE_ID 1

`endif
